// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP      := tb_sparse_top
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: ctrl_pkg.sv
package ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ACCUM = 2'd1,
    DRAIN = 2'd2,
    HOLD  = 2'd3
  } ctrl_state_e;

  typedef enum logic [1:0] {
    MAC_HOLD  = 2'd0,
    MAC_START = 2'd1,
    MAC_ACC   = 2'd2,
    MAC_LAST  = 2'd3
  } mac_op_e;

endpackage

// File: flow_controller.sv
`timescale 1ns/1ns

module flow_controller (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    weights_valid,
  output logic    weights_ready,
  input  logic    act_valid,
  input  logic    act_last,
  output logic    act_ready,
  input  logic    out_valid,
  input  logic    out_ready,
  mac_ctrl_if.ctrl bus
);
  import ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  mac_op_e     op_q;
  logic        accept;
  logic        first_q;
  logic        drain_cnt;

  assign accept = act_valid && act_ready;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = act_last ? DRAIN : ACCUM;
        end
      end
      ACCUM: begin
        if (accept && act_last) begin
          state_next = DRAIN;
        end
      end
      // Two cycles for the decoder and MAC stages to empty
      DRAIN: begin
        if (drain_cnt) begin
          state_next = HOLD;
        end
      end
      HOLD: begin
        if (out_valid && out_ready) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= IDLE;
      op_q          <= MAC_HOLD;
      first_q       <= 1'b1;
      drain_cnt     <= 1'b0;
      act_ready     <= 1'b0;
      weights_ready <= 1'b0;
    end else begin
      state         <= state_next;
      drain_cnt     <= (state == DRAIN) && !drain_cnt;
      act_ready     <= (state_next == IDLE) || (state_next == ACCUM);
      weights_ready <= (state_next == IDLE);
      if (accept) begin
        first_q <= 1'b0;
      end else if (state_next == IDLE) begin
        first_q <= 1'b1;
      end
      // Delayed one cycle to line up with the decoded lanes
      if (!accept) begin
        op_q <= MAC_HOLD;
      end else if (act_last) begin
        op_q <= MAC_LAST;
      end else begin
        op_q <= first_q ? MAC_START : MAC_ACC;
      end
    end
  end

  assign bus.op          = op_q;
  assign bus.weight_load = weights_valid && weights_ready;

endmodule

// File: mac_ctrl_if.sv
`timescale 1ns/1ns

interface mac_ctrl_if #(
  parameter int WORD_W = 32
);
  import ctrl_pkg::*;

  mac_op_e           op;
  logic              weight_load;
  logic [WORD_W-1:0] weight_word;
  logic              acc_done;

  modport ctrl (output op, output weight_load);

  modport mac (input op, input weight_load, input weight_word, output acc_done);

  // Encoder only needs to know when the sums are final
  modport cap (input acc_done);

endinterface

// File: mac_lanes.sv
`timescale 1ns/1ns

module mac_lanes #(
  parameter int LANES  = 4,
  parameter int DATA_W = 8,
  parameter int ACC_W  = 24
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [LANES*DATA_W-1:0] dec_lanes,
  mac_ctrl_if.mac                 bus,
  output logic [LANES*ACC_W-1:0]  acc_lanes
);
  import ctrl_pkg::*;

  logic [LANES*DATA_W-1:0] weight_q;
  logic signed [ACC_W-1:0] acc_q    [LANES];
  logic signed [ACC_W-1:0] acc_next [LANES];
  logic signed [ACC_W-1:0] prod     [LANES];
  logic                    restart;
  logic                    fresh_q;
  logic                    acc_done_q;

  // A single-word group sees MAC_LAST first, so it must not add to a stale sum
  assign restart = (bus.op == MAC_START) || ((bus.op == MAC_LAST) && fresh_q);

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      // Activation is unsigned, weight is signed
      prod[i] = $signed({1'b0, dec_lanes[i*DATA_W +: DATA_W]})
                * $signed(weight_q[i*DATA_W +: DATA_W]);
      acc_next[i] = (restart ? '0 : acc_q[i]) + prod[i];
      acc_lanes[i*ACC_W +: ACC_W] = acc_q[i];
    end
  end

  always_ff @(posedge clk) begin
    if (bus.weight_load) begin
      weight_q <= bus.weight_word;
    end
    if (bus.op != MAC_HOLD) begin
      acc_q <= acc_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_done_q <= 1'b0;
      fresh_q    <= 1'b1;
    end else begin
      acc_done_q <= (bus.op == MAC_LAST);
      if (bus.op == MAC_LAST) begin
        fresh_q <= 1'b1;
      end else if (bus.op != MAC_HOLD) begin
        fresh_q <= 1'b0;
      end
    end
  end

  assign bus.acc_done = acc_done_q;

endmodule

// File: result_encoder.sv
`timescale 1ns/1ns

module result_encoder #(
  parameter int LANES     = 4,
  parameter int DATA_W    = 8,
  parameter int ACC_W     = 24,
  parameter int OUT_SHIFT = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [LANES*ACC_W-1:0]  acc_lanes,
  mac_ctrl_if.cap                 bus,
  input  logic                    out_ready,
  output logic [LANES*DATA_W-1:0] out_packed,
  output logic [LANES-1:0]        out_mask,
  output logic                    out_valid
);

  localparam logic signed [ACC_W-1:0] Q_MAX = ACC_W'((1 << DATA_W) - 1);

  logic [LANES*DATA_W-1:0] packed_d;
  logic [LANES-1:0]        mask_d;

  always_comb begin
    logic signed [ACC_W-1:0] shifted;
    logic [DATA_W-1:0]       q;
    int                      idx;
    idx      = 0;
    packed_d = '0;
    for (int i = 0; i < LANES; i++) begin
      shifted = $signed(acc_lanes[i*ACC_W +: ACC_W]) >>> OUT_SHIFT;
      // Lower clamp doubles as ReLU
      if (shifted < 0) begin
        q = '0;
      end else if (shifted > Q_MAX) begin
        q = '1;
      end else begin
        q = shifted[DATA_W-1:0];
      end
      mask_d[i] = |q;
      if (|q) begin
        packed_d[idx*DATA_W +: DATA_W] = q;
        idx = idx + 1;
      end
    end
  end

  // Payload only changes on capture, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (bus.acc_done) begin
      out_packed <= packed_d;
      out_mask   <= mask_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (bus.acc_done) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

// File: sparse_cfg_pkg.sv
package sparse_cfg_pkg;

  // Lanes per compressed word, one mask bit each
  localparam int LANES_DEF = 4;

  // Activation and weight width per lane
  localparam int DATA_W_DEF = 8;

  // Per-lane accumulator, wide enough for long groups
  localparam int ACC_W_DEF = 24;

  // Requantization shift before the clamp
  localparam int SHIFT_DEF = 4;

endpackage

// File: sparse_checker.sv
`timescale 1ns/1ns

module sparse_checker #(
  parameter int LANES  = sparse_cfg_pkg::LANES_DEF,
  parameter int DATA_W = sparse_cfg_pkg::DATA_W_DEF
) (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    act_ready,
  input logic                    weights_ready,
  input logic                    out_valid,
  input logic                    out_ready,
  input logic [LANES*DATA_W-1:0] out_packed,
  input logic [LANES-1:0]        out_mask
);

  int fail_count;

  // Stalled result keeps its payload
  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_packed) && $stable(out_mask))
  else begin
    fail_count++;
    $error("output payload changed while stalled");
  end

  excl_a: assert property (@(posedge clk) disable iff (!rst_n) !(act_ready && out_valid))
  else begin
    fail_count++;
    $error("act_ready and out_valid high together");
  end

  // Weights only move while the pipeline is idle
  wready_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!act_ready || out_valid) |-> !weights_ready)
  else begin
    fail_count++;
    $error("weights_ready high outside idle");
  end

endmodule

bind sparse_top sparse_checker #(.LANES(LANES), .DATA_W(DATA_W)) protocol_chk (
  .clk(clk), .rst_n(rst_n), .act_ready(act_ready), .weights_ready(weights_ready),
  .out_valid(out_valid), .out_ready(out_ready),
  .out_packed(out_packed), .out_mask(out_mask)
);

// File: sparse_decoder.sv
`timescale 1ns/1ns

module sparse_decoder #(
  parameter int LANES  = 4,
  parameter int DATA_W = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [LANES*DATA_W-1:0] act_packed,
  input  logic [LANES-1:0]        act_mask,
  input  logic                    act_valid,
  input  logic                    act_ready,
  output logic [LANES*DATA_W-1:0] dec_lanes
);

  logic                    accept;
  logic [LANES*DATA_W-1:0] lanes_d;

  assign accept = act_valid && act_ready;

  // k-th packed byte goes to the lane of the k-th set mask bit
  always_comb begin
    int idx;
    idx = 0;
    for (int i = 0; i < LANES; i++) begin
      lanes_d[i*DATA_W +: DATA_W] = '0;
      if (act_mask[i]) begin
        lanes_d[i*DATA_W +: DATA_W] = act_packed[idx*DATA_W +: DATA_W];
        idx = idx + 1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_lanes <= '0;
    end else if (accept) begin
      dec_lanes <= lanes_d;
    end
  end

endmodule

// File: sparse_top.sv
`timescale 1ns/1ns

module sparse_top #(
  parameter int LANES     = sparse_cfg_pkg::LANES_DEF,
  parameter int DATA_W    = sparse_cfg_pkg::DATA_W_DEF,
  parameter int ACC_W     = sparse_cfg_pkg::ACC_W_DEF,
  parameter int OUT_SHIFT = sparse_cfg_pkg::SHIFT_DEF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [LANES*DATA_W-1:0] weights_in,
  input  logic                    weights_valid,
  output logic                    weights_ready,
  input  logic [LANES*DATA_W-1:0] act_packed,
  input  logic [LANES-1:0]        act_mask,
  input  logic                    act_last,
  input  logic                    act_valid,
  output logic                    act_ready,
  output logic [LANES*DATA_W-1:0] out_packed,
  output logic [LANES-1:0]        out_mask,
  output logic                    out_valid,
  input  logic                    out_ready
);

  logic [LANES*DATA_W-1:0] dec_lanes;
  logic [LANES*ACC_W-1:0]  acc_lanes;

  mac_ctrl_if #(.WORD_W(LANES*DATA_W)) mac_bus ();

  assign mac_bus.weight_word = weights_in;

  flow_controller controller (
    .clk(clk), .rst_n(rst_n),
    .weights_valid(weights_valid), .weights_ready(weights_ready),
    .act_valid(act_valid), .act_last(act_last), .act_ready(act_ready),
    .out_valid(out_valid), .out_ready(out_ready),
    .bus(mac_bus.ctrl)
  );

  sparse_decoder #(.LANES(LANES), .DATA_W(DATA_W)) decoder (
    .clk(clk), .rst_n(rst_n),
    .act_packed(act_packed), .act_mask(act_mask),
    .act_valid(act_valid), .act_ready(act_ready),
    .dec_lanes(dec_lanes)
  );

  mac_lanes #(.LANES(LANES), .DATA_W(DATA_W), .ACC_W(ACC_W)) mac (
    .clk(clk), .rst_n(rst_n),
    .dec_lanes(dec_lanes), .bus(mac_bus.mac), .acc_lanes(acc_lanes)
  );

  result_encoder #(
    .LANES(LANES), .DATA_W(DATA_W), .ACC_W(ACC_W), .OUT_SHIFT(OUT_SHIFT)
  ) encoder (
    .clk(clk), .rst_n(rst_n),
    .acc_lanes(acc_lanes), .bus(mac_bus.cap), .out_ready(out_ready),
    .out_packed(out_packed), .out_mask(out_mask), .out_valid(out_valid)
  );

endmodule

// File: tb_sparse_top.sv
`timescale 1ns/1ns

module tb_sparse_top;
  import sparse_cfg_pkg::*;

  localparam int LANES     = LANES_DEF;
  localparam int DW        = DATA_W_DEF;
  localparam int WORD_W    = LANES * DW;
  localparam int N_RANDOM  = 50;
  localparam int MAX_LEN   = 6;
  localparam int MAX_STALL = 16;
  // Bubbles can double a group's length in cycles
  localparam int TIMEOUT = (N_RANDOM + 3) * (2 * MAX_LEN + 3 + MAX_STALL) + 200;

  logic              clk;
  logic              rst_n;
  logic [WORD_W-1:0] weights_in;
  logic              weights_valid;
  logic              weights_ready;
  logic [WORD_W-1:0] act_packed;
  logic [LANES-1:0]  act_mask;
  logic              act_last;
  logic              act_valid;
  logic              act_ready;
  logic [WORD_W-1:0] out_packed;
  logic [LANES-1:0]  out_mask;
  logic              out_valid;
  logic              out_ready;

  logic [31:0]             lfsr;
  logic [31:0]             rdy_lfsr;
  logic [LANES+WORD_W-1:0] exp_q [$];
  logic [LANES+WORD_W-1:0] exp_w;
  logic [WORD_W-1:0]       m_weight;
  int                      m_acc [LANES];
  bit                      in_group;
  // DUT outputs as seen in the middle of the cycle
  logic                    ar_s;
  logic                    wr_s;
  logic                    ov_s;
  logic [WORD_W-1:0]       op_s;
  logic [LANES-1:0]        om_s;
  bit                      held;
  logic [WORD_W-1:0]       held_packed;
  logic [LANES-1:0]        held_mask;
  bit                      lat_on;
  int                      lat_cnt;
  int                      cycles;
  int                      groups_sent;
  int                      results_seen;
  int                      mismatches;
  int                      failures;
  int                      assert_fails;

  sparse_top UUT (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Shift, clamp to a byte, then compress
  function automatic logic [LANES+WORD_W-1:0] expected_word();
    logic [LANES-1:0]  mask;
    logic [WORD_W-1:0] pk;
    int                v;
    int                k;
    mask = '0;
    pk   = '0;
    k    = 0;
    for (int i = 0; i < LANES; i++) begin
      v = m_acc[i] >>> SHIFT_DEF;
      v = (v < 0) ? 0 : (v > (1 << DW) - 1) ? (1 << DW) - 1 : v;
      if (v != 0) begin
        mask[i] = 1'b1;
        pk[k*DW +: DW] = v[DW-1:0];
        k++;
      end
    end
    return {mask, pk};
  endfunction

  task automatic model_word(input logic [WORD_W-1:0] pk, input logic [LANES-1:0] mask);
    int k;
    int a;
    k = 0;
    for (int i = 0; i < LANES; i++) begin
      a = 0;
      if (mask[i]) begin
        a = pk[k*DW +: DW];
        k++;
      end
      if (!in_group) begin
        m_acc[i] = 0;
      end
      m_acc[i] += a * $signed(m_weight[i*DW +: DW]);
    end
  endtask

  task automatic send_word(input logic [WORD_W-1:0] pk, input logic [LANES-1:0] mask,
                           input logic last);
    act_packed = pk;
    act_mask   = mask;
    act_last   = last;
    act_valid  = 1'b1;
    while (!act_ready) @(negedge clk);
    @(negedge clk);
    act_valid = 1'b0;
    if (last) begin
      groups_sent++;
    end
  endtask

  task automatic offer_weights(input logic [WORD_W-1:0] w, input int delay);
    repeat (delay) @(negedge clk);
    weights_in    = w;
    weights_valid = 1'b1;
    while (!weights_ready) @(negedge clk);
    @(negedge clk);
    weights_valid = 1'b0;
  endtask

  task automatic send_group(input int len, input bit dense);
    logic [WORD_W-1:0] pk;
    logic [LANES-1:0]  mask;
    logic [31:0]       b;
    int                k;
    for (int n = 0; n < len; n++) begin
      pk   = '0;
      k    = 0;
      mask = dense ? '1 : LANES'(rand_bits(LANES));
      // Now and then thin the mask further, possibly to nothing
      if (!dense && rand_bits(1)) begin
        mask &= LANES'(rand_bits(LANES));
      end
      for (int i = 0; i < LANES; i++) begin
        if (mask[i]) begin
          b = dense ? 32'hff : rand_bits(DW);
          pk[k*DW +: DW] = (b[DW-1:0] == '0) ? DW'(1) : b[DW-1:0];
          k++;
        end
      end
      if (!dense && rand_bits(2) == 0) begin
        @(negedge clk);
      end
      send_word(pk, mask, n == len - 1);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random back-pressure on about one cycle in four
  always @(negedge clk) begin
    rdy_lfsr  = lfsr_step(lfsr_step(rdy_lfsr));
    out_ready = rdy_lfsr[0] | rdy_lfsr[1];
  end

  always @(negedge clk) begin
    ar_s = act_ready;
    wr_s = weights_ready;
    ov_s = out_valid;
    op_s = out_packed;
    om_s = out_mask;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d results outstanding", cycles, exp_q.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (held) begin
        assert (ov_s && op_s == held_packed && om_s == held_mask) else begin
          mismatches++;
          $display("Mismatch at %0t: output changed while stalled", $time);
        end
      end
      held        = ov_s && !out_ready;
      held_packed = op_s;
      held_mask   = om_s;
      if (lat_on && ov_s) begin
        assert (lat_cnt == 3) else begin
          mismatches++;
          $display("Mismatch at %0t: latency %0d edges, expected 3", $time, lat_cnt);
        end
        lat_on = 1'b0;
      end
      if (lat_on) begin
        lat_cnt++;
      end
      assert (!(ar_s && exp_q.size() != 0)) else begin
        failures++;
        $display("act_ready was high at %0t while a result was outstanding", $time);
      end
      if (weights_valid && wr_s) begin
        assert (!in_group && exp_q.size() == 0) else begin
          failures++;
          $display("Weights were taken at %0t in the middle of a group", $time);
        end
        m_weight = weights_in;
      end
      if (act_valid && ar_s) begin
        model_word(act_packed, act_mask);
        in_group = !act_last;
        if (act_last) begin
          exp_q.push_back(expected_word());
          lat_on  = 1'b1;
          lat_cnt = 1;
        end
      end
      if (ov_s && out_ready) begin
        assert (exp_q.size() != 0) else begin
          failures++;
          $display("An output arrived at %0t with no result expected", $time);
        end
        if (exp_q.size() != 0) begin
          exp_w = exp_q.pop_front();
          results_seen++;
          assert ({om_s, op_s} == exp_w) else begin
            mismatches++;
            $display("Mismatch at %0t: mask %b packed %h, expected mask %b packed %h",
                     $time, om_s, op_s, exp_w[WORD_W +: LANES], exp_w[WORD_W-1:0]);
          end
        end
      end
    end
  end

  initial begin
    logic [WORD_W-1:0] w;
    int                len;
    int                d;
    lfsr          = 32'h242ab2e9;
    rdy_lfsr      = 32'h242ab2e9;
    rst_n         = 1'b0;
    weights_in    = '0;
    weights_valid = 1'b0;
    act_packed    = '0;
    act_mask      = '0;
    act_last      = 1'b0;
    act_valid     = 1'b0;
    out_ready     = 1'b1;
    m_weight      = '0;
    @(negedge clk);
    assert (!out_valid && !weights_ready && !act_ready) else begin
      failures++;
      $display("Handshake outputs were not low during reset");
    end
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid && weights_ready && act_ready) else begin
      failures++;
      $display("Controller was not ready in the first cycle after reset");
    end

    // Single word, mixed-sign weights
    offer_weights(32'h05fd1001, 0);
    send_word(32'h0040_90ff, 4'b1101, 1'b1);
    // Full groups at the extremes of the clamp
    offer_weights({LANES{8'h80}}, 0);
    send_group(MAX_LEN, 1'b1);
    offer_weights({LANES{8'h7f}}, 0);
    send_group(MAX_LEN, 1'b1);

    for (int g = 0; g < N_RANDOM; g++) begin
      len = 1 + rand_bits(8) % MAX_LEN;
      if (rand_bits(2) == 0) begin
        w = rand_bits(WORD_W);
        d = rand_bits(3);
        fork
          offer_weights(w, d);
          send_group(len, 1'b0);
        join
      end else begin
        send_group(len, 1'b0);
      end
    end

    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    assert (results_seen == groups_sent) else begin
      failures++;
      $display("Saw %0d results for %0d groups", results_seen, groups_sent);
    end
    assert_fails = UUT.protocol_chk.fail_count;
    $display("Errors: %0d mismatches, %0d other, %0d protocol; %0d results checked",
             mismatches, failures, assert_fails, results_seen);
    if (mismatches == 0 && failures == 0 && assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
sparse_cfg_pkg.sv
ctrl_pkg.sv
mac_ctrl_if.sv
sparse_decoder.sv
mac_lanes.sv
result_encoder.sv
flow_controller.sv
sparse_top.sv
sparse_checker.sv
tb_sparse_top.sv
